// File: hw/fifo_pkg.sv
package fifo_pkg;

  // --------------------------------------------------
  // sizes and thresholds
  // --------------------------------------------------
  localparam int DATA_WIDTH  = 8;
  localparam int FIFO_DEPTH  = 16;
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH);
  localparam int FIFO_AFULL  = 12;  // write side, at or above
  localparam int FIFO_AEMPTY = 2;   // read side, at or below

  // --------------------------------------------------
  // gray conversion, pointer width
  // --------------------------------------------------
  function automatic logic [ADDR_WIDTH:0] bin2gray(
    input logic [ADDR_WIDTH:0] bin
  );
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [ADDR_WIDTH:0] gray2bin(
    input logic [ADDR_WIDTH:0] gray
  );
    logic [ADDR_WIDTH:0] bin;
    bin[ADDR_WIDTH] = gray[ADDR_WIDTH];  // msb passes straight
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: hw/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram
  import fifo_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // --------------------------------------------------
  // write port
  // --------------------------------------------------
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // --------------------------------------------------
  // read port
  // --------------------------------------------------
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];  // holds between reads
    end
  end

endmodule

// File: hw/wr_ptr_full.sv
`timescale 1ns/1ps

module wr_ptr_full
  import fifo_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH:0]   rd_gray,
  output logic                  wr_vld,
  output logic [ADDR_WIDTH-1:0] wr_addr,
  output logic [ADDR_WIDTH:0]   wr_gray,
  output logic                  full,
  output logic                  afull
);

  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_nxt;
  logic [ADDR_WIDTH:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_gray_sync1;
  logic [ADDR_WIDTH:0] rd_gray_sync2;
  logic [ADDR_WIDTH:0] rd_bin_sync;
  logic [ADDR_WIDTH:0] wr_used;
  logic                full_comb;
  logic                afull_comb;

  assign wr_vld = wr_en && !full;  // drop writes while full

  // --------------------------------------------------
  // write pointer, binary and gray
  // --------------------------------------------------
  assign wr_bin_nxt  = wr_bin + {{ADDR_WIDTH{1'b0}}, wr_vld};
  assign wr_gray_nxt = bin2gray(wr_bin_nxt);
  assign wr_addr     = wr_bin[ADDR_WIDTH-1:0];

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;  // only this copy crosses
    end
  end

  // --------------------------------------------------
  // read pointer into wr_clk
  // --------------------------------------------------
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_sync1 <= '0;
      rd_gray_sync2 <= '0;
    end else begin
      rd_gray_sync1 <= rd_gray;
      rd_gray_sync2 <= rd_gray_sync1;
    end
  end

  // full when one lap ahead of the read pointer
  assign full_comb = (wr_gray_nxt ==
                      {~rd_gray_sync2[ADDR_WIDTH:ADDR_WIDTH-1],
                       rd_gray_sync2[ADDR_WIDTH-2:0]});

  assign rd_bin_sync = gray2bin(rd_gray_sync2);
  assign wr_used     = wr_bin_nxt - rd_bin_sync;  // wraps cleanly
  assign afull_comb  = (wr_used >= (ADDR_WIDTH+1)'(FIFO_AFULL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_comb;
      afull <= afull_comb;
    end
  end

endmodule

// File: hw/rd_ptr_empty.sv
`timescale 1ns/1ps

module rd_ptr_empty
  import fifo_pkg::*;
(
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH:0]   wr_gray,
  output logic                  rd_vld,
  output logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [ADDR_WIDTH:0]   rd_gray,
  output logic                  empty,
  output logic                  aempty
);

  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_nxt;
  logic [ADDR_WIDTH:0] rd_gray_nxt;
  logic [ADDR_WIDTH:0] wr_gray_sync1;
  logic [ADDR_WIDTH:0] wr_gray_sync2;
  logic [ADDR_WIDTH:0] wr_bin_sync;
  logic [ADDR_WIDTH:0] rd_used;
  logic                empty_comb;
  logic                aempty_comb;

  assign rd_vld = rd_en && !empty;  // drop reads while empty

  // --------------------------------------------------
  // read pointer, binary and gray
  // --------------------------------------------------
  assign rd_bin_nxt  = rd_bin + {{ADDR_WIDTH{1'b0}}, rd_vld};
  assign rd_gray_nxt = bin2gray(rd_bin_nxt);
  assign rd_addr     = rd_bin[ADDR_WIDTH-1:0];

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // --------------------------------------------------
  // write pointer into rd_clk
  // --------------------------------------------------
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_sync1 <= '0;
      wr_gray_sync2 <= '0;
    end else begin
      wr_gray_sync1 <= wr_gray;
      wr_gray_sync2 <= wr_gray_sync1;
    end
  end

  // pointers equal in all bits means nothing left
  assign empty_comb = (rd_gray_nxt == wr_gray_sync2);

  assign wr_bin_sync = gray2bin(wr_gray_sync2);
  assign rd_used     = wr_bin_sync - rd_bin_nxt;
  assign aempty_comb = (rd_used <= (ADDR_WIDTH+1)'(FIFO_AEMPTY));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;  // nothing stored out of reset
      aempty <= 1'b1;
    end else begin
      empty  <= empty_comb;
      aempty <= aempty_comb;
    end
  end

endmodule

// File: hw/async_fifo.sv
`timescale 1ns/1ps

module async_fifo
  import fifo_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  empty,
  output logic                  afull,
  output logic                  aempty
);

  logic                  wr_vld;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH:0]   wr_gray;  // crosses to rd_clk
  logic                  rd_vld;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [ADDR_WIDTH:0]   rd_gray;  // crosses to wr_clk

  // --------------------------------------------------
  // write domain
  // --------------------------------------------------
  wr_ptr_full u_wr_ptr_full (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .rd_gray  (rd_gray),
    .wr_vld   (wr_vld),
    .wr_addr  (wr_addr),
    .wr_gray  (wr_gray),
    .full     (full),
    .afull    (afull)
  );

  // --------------------------------------------------
  // read domain
  // --------------------------------------------------
  rd_ptr_empty u_rd_ptr_empty (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .wr_gray  (wr_gray),
    .rd_vld   (rd_vld),
    .rd_addr  (rd_addr),
    .rd_gray  (rd_gray),
    .empty    (empty),
    .aempty   (aempty)
  );

  // storage, written and read only on accepted strobes
  dual_port_ram u_dual_port_ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_vld),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_vld),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// File: bench/async_fifo_props.sv
`timescale 1ns/1ps

module async_fifo_props
  import fifo_pkg::*;
(
  input logic                wr_clk,
  input logic                wr_rst_n,
  input logic                rd_clk,
  input logic                rd_rst_n,
  input logic                full,
  input logic                afull,
  input logic                empty,
  input logic                aempty,
  input logic [ADDR_WIDTH:0] wr_gray,
  input logic [ADDR_WIDTH:0] rd_gray
);

  // --------------------------------------------------
  // flag relations
  // --------------------------------------------------
  full_has_afull: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    full |-> afull) else $error("full set while afull low");

  empty_has_aempty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    empty |-> aempty) else $error("empty set while aempty low");

  // --------------------------------------------------
  // gray pointers move one bit at a time
  // --------------------------------------------------
  wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1) else $error("wr_gray jumped");

  rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1) else $error("rd_gray jumped");

endmodule

bind async_fifo async_fifo_props u_props (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .full     (full),
  .afull    (afull),
  .empty    (empty),
  .aempty   (aempty),
  .wr_gray  (wr_gray),
  .rd_gray  (rd_gray)
);

// File: bench/async_fifo_tb.sv
`timescale 1ns/1ps

module async_fifo_tb
  import fifo_pkg::*;
();

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_CONC, OP_SETTLE} op_e;

  // flags and care bits ordered {full, empty, afull, aempty}
  typedef struct packed {
    op_e        op;
    int         cnt;
    logic [3:0] care;
    logic [3:0] flags;
  } row_t;

  localparam int NUM_ROWS   = 18;
  localparam int SETTLE_CYC = 10;  // cycles of wr_clk, the slower one

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  full;
  logic                  empty;
  logic                  afull;
  logic                  aempty;

  row_t                  rows [NUM_ROWS];
  logic [DATA_WIDTH-1:0] model_q [$];
  logic [DATA_WIDTH-1:0] last_rd;
  logic [31:0]           wr_rng;
  logic [31:0]           rd_rng;
  int                    errors;
  int                    checks;
  int                    cycles;
  int                    timeout_limit;

  async_fifo DUT (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever #10 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #13 wr_clk = ~wr_clk;  // drifts against rd_clk
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int run_limit();
    int total;
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += (rows[r].op == OP_SETTLE) ? SETTLE_CYC : rows[r].cnt;
    end
    return 4 * total;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("Error: time %0t, %s = %0b, expected %0b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error: time %0t, %s = %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // row operations
  // --------------------------------------------------
  task automatic write_burst(input int n);
    for (int i = 0; i <= n; i++) begin
      @(negedge wr_clk);
      if (i > 0) begin  // read side idle, so flags follow the model
        check_bit("full", full, model_q.size() == FIFO_DEPTH);
        check_bit("afull", afull, model_q.size() >= FIFO_AFULL);
      end
      if (i < n) begin
        wr_rng  = next_random(wr_rng);
        wr_en   = 1'b1;
        wr_data = wr_rng[DATA_WIDTH-1:0];
        if (!full) model_q.push_back(wr_data);
      end else begin
        wr_en = 1'b0;
      end
    end
  endtask

  task automatic read_burst(input int n);
    logic                  pending;
    logic [DATA_WIDTH-1:0] want;
    pending = 1'b0;
    want    = '0;
    for (int i = 0; i <= n; i++) begin
      @(negedge rd_clk);
      if (i > 0) begin
        if (pending) begin
          check_word("rd_data", rd_data, want);
          last_rd = want;
        end else begin
          check_word("rd_data", rd_data, last_rd);  // dropped read
        end
        check_bit("empty", empty, model_q.size() == 0);
        check_bit("aempty", aempty, model_q.size() <= FIFO_AEMPTY);
      end
      if (i < n) begin
        rd_en   = 1'b1;
        pending = !empty;
        if (pending) want = model_q.pop_front();
      end else begin
        rd_en = 1'b0;
      end
    end
  endtask

  task automatic concurrent_traffic(input int n);
    logic                  pending;
    logic [DATA_WIDTH-1:0] want;
    pending = 1'b0;
    want    = '0;
    fork
      begin : writer
        for (int i = 0; i < n; i++) begin
          @(negedge wr_clk);
          wr_rng  = next_random(wr_rng);
          wr_en   = (wr_rng[1:0] != 2'b00);  // about three in four
          wr_data = wr_rng[DATA_WIDTH+7:8];
          if (wr_en && !full) model_q.push_back(wr_data);
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
      end
      begin : reader
        for (int i = 0; i <= n; i++) begin
          @(negedge rd_clk);
          if (pending) begin
            check_word("rd_data", rd_data, want);
            last_rd = want;
          end
          if (i < n) begin
            rd_rng  = next_random(rd_rng);
            rd_en   = rd_rng[0];
            pending = rd_en && !empty;
            if (pending) want = model_q.pop_front();
          end else begin
            rd_en   = 1'b0;
            pending = 1'b0;
          end
        end
      end
    join
  endtask

  task automatic settle();
    repeat (SETTLE_CYC) @(posedge wr_clk);
    @(negedge rd_clk);
    check_bit("full", full, model_q.size() == FIFO_DEPTH);
    check_bit("empty", empty, model_q.size() == 0);
    check_bit("afull", afull, model_q.size() >= FIFO_AFULL);
    check_bit("aempty", aempty, model_q.size() <= FIFO_AEMPTY);
  endtask

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  always @(posedge rd_clk) begin
    cycles++;
    if (cycles >= timeout_limit) begin
      $display("timeout: run did not finish within %0d rd_clk cycles", timeout_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int  errs_before;
    op_e op;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    errors   = 0;
    checks   = 0;
    last_rd  = '0;  // rd_data out of reset
    wr_rng   = 32'hb84a_7995;
    rd_rng   = next_random(32'hb84a_7995);

    rows[0]  = '{OP_SETTLE, 0,   4'b1111, 4'b0101};
    rows[1]  = '{OP_READ,   2,   4'b1111, 4'b0101};  // reads while empty
    rows[2]  = '{OP_WRITE,  19,  4'b1010, 4'b1010};  // 3 dropped
    rows[3]  = '{OP_SETTLE, 0,   4'b1111, 4'b1010};
    rows[4]  = '{OP_READ,   16,  4'b0101, 4'b0101};
    rows[5]  = '{OP_SETTLE, 0,   4'b1111, 4'b0101};
    rows[6]  = '{OP_WRITE,  2,   4'b1010, 4'b0000};
    rows[7]  = '{OP_SETTLE, 0,   4'b1111, 4'b0001};  // occupancy 2
    rows[8]  = '{OP_WRITE,  1,   4'b1010, 4'b0000};
    rows[9]  = '{OP_SETTLE, 0,   4'b1111, 4'b0000};  // occupancy 3
    rows[10] = '{OP_WRITE,  9,   4'b1010, 4'b0010};
    rows[11] = '{OP_SETTLE, 0,   4'b1111, 4'b0010};  // occupancy 12
    rows[12] = '{OP_READ,   1,   4'b0101, 4'b0000};
    rows[13] = '{OP_SETTLE, 0,   4'b1111, 4'b0000};  // occupancy 11
    rows[14] = '{OP_CONC,   400, 4'b0000, 4'b0000};
    rows[15] = '{OP_SETTLE, 0,   4'b0000, 4'b0000};
    rows[16] = '{OP_READ,   20,  4'b0101, 4'b0101};  // drain
    rows[17] = '{OP_SETTLE, 0,   4'b1111, 4'b0101};

    cycles        = 0;
    timeout_limit = run_limit();

    repeat (8) @(posedge rd_clk);
    @(negedge rd_clk);
    rd_rst_n = 1'b1;
    @(negedge wr_clk);
    wr_rst_n = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      errs_before = errors;
      op          = rows[r].op;
      case (op)
        OP_WRITE: write_burst(rows[r].cnt);
        OP_READ:  read_burst(rows[r].cnt);
        OP_CONC:  concurrent_traffic(rows[r].cnt);
        default:  settle();
      endcase
      if (rows[r].care[3]) check_bit("full", full, rows[r].flags[3]);
      if (rows[r].care[2]) check_bit("empty", empty, rows[r].flags[2]);
      if (rows[r].care[1]) check_bit("afull", afull, rows[r].flags[1]);
      if (rows[r].care[0]) check_bit("aempty", aempty, rows[r].flags[0]);
      $display("row %0d %s count %0d: %s", r, op.name(), rows[r].cnt,
               (errors == errs_before) ? "ok" : "mismatch");
    end

    checks++;
    assert (model_q.size() == 0) else begin
      $display("model still holds %0d words after the drain", model_q.size());
      errors++;
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: async_fifo.f
hw/fifo_pkg.sv
hw/dual_port_ram.sv
hw/wr_ptr_full.sv
hw/rd_ptr_empty.sv
hw/async_fifo.sv
bench/async_fifo_props.sv
bench/async_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the async FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f async_fifo.f --top-module async_fifo_tb -o async_fifo_sim \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/async_fifo_sim 2>&1)
echo "$out"

echo "$out" | grep -q "ALL CHECKS PASSED" \
  && { echo "result: pass"; exit 0; } \
  || { echo "result: fail"; exit 1; }
